// File: logic/d_cache_params.svh
`ifndef D_CACHE_PARAMS_SVH
`define D_CACHE_PARAMS_SVH

// ============================================================
// Address split and line geometry
// ============================================================

`define D_CACHE_ADDR_BITS   32
`define D_CACHE_OFFSET_BITS 5   // Byte offset inside a 32-byte line.
`define D_CACHE_INDEX_BITS  4   // Selects one of the sets.
`define D_CACHE_TAG_BITS    (`D_CACHE_ADDR_BITS - `D_CACHE_OFFSET_BITS - `D_CACHE_INDEX_BITS)

`define D_CACHE_LINE_BITS   256
`define D_CACHE_SETS        16  // Must equal 2**D_CACHE_INDEX_BITS.

`endif

// File: logic/d_cache_pkg.sv
`include "d_cache_params.svh"

package d_cache_pkg;

    // ============================================================
    // Vector types
    // ============================================================

    typedef logic [`D_CACHE_ADDR_BITS-1:0]      addr_t;
    typedef logic [`D_CACHE_LINE_BITS-1:0]      line_t;
    typedef logic [`D_CACHE_LINE_BITS/8-1:0]    byte_mask_t;   // One bit per byte of the line.
    typedef logic [`D_CACHE_TAG_BITS-1:0]       tag_t;
    typedef logic [`D_CACHE_INDEX_BITS-1:0]     index_t;

    // ============================================================
    // Bundles between CPU, control and datapath
    // ============================================================

    typedef struct packed {
        addr_t      address;
        byte_mask_t byte_enable;
        line_t      wdata;
    } cpu_req_t;

    typedef struct packed {
        logic load_fill;    // Fetched line goes into the victim way.
        logic store_cpu;    // CPU bytes merge into the hit way.
        logic touch_lru;
        logic wb_address;   // Memory address comes from the victim tag.
    } ctrl_t;

    typedef struct packed {
        logic hit;
        logic victim_dirty;
    } status_t;

    typedef enum logic [1:0] {
        compare,
        writeback,
        fill
    } cache_state_t;

endpackage : d_cache_pkg

// File: logic/d_cache_way.sv
`timescale 1ns/1ps
`include "d_cache_params.svh"

module d_cache_way (
    input  logic                    clk,
    input  logic                    reset,

    input  d_cache_pkg::index_t     index,
    input  d_cache_pkg::tag_t       tag_in,

    input  logic                    fill,
    input  d_cache_pkg::line_t      fill_line,
    input  logic                    store,
    input  d_cache_pkg::byte_mask_t store_mask,
    input  d_cache_pkg::line_t      store_line,

    output logic                    valid,
    output logic                    dirty,
    output d_cache_pkg::tag_t       tag,
    output d_cache_pkg::line_t      line
);

    d_cache_pkg::tag_t          tag_q  [`D_CACHE_SETS];
    d_cache_pkg::line_t         line_q [`D_CACHE_SETS];
    logic [`D_CACHE_SETS-1:0]   valid_q;
    logic [`D_CACHE_SETS-1:0]   dirty_q;
    d_cache_pkg::line_t         merged;

    // Only the enabled bytes of the stored line replace the old ones.
    always_comb begin
        merged = line_q[index];
        for (int b = 0; b < `D_CACHE_LINE_BITS/8; b++) begin
            if (store_mask[b]) begin
                merged[8*b +: 8] = store_line[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;     // A freshly fetched line matches memory.
        end else if (store) begin
            dirty_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[index]  <= tag_in;
            line_q[index] <= fill_line;
        end else if (store) begin
            line_q[index] <= merged;
        end
    end

    assign valid = valid_q[index];
    assign dirty = dirty_q[index];
    assign tag   = tag_q[index];
    assign line  = line_q[index];

    // ============================================================
    // Checks
    // ============================================================

    fill_store_excl : assert property (@(posedge clk) disable iff (reset)
        !(fill && store));

endmodule : d_cache_way

// File: logic/d_cache_datapath.sv
`timescale 1ns/1ps
`include "d_cache_params.svh"

module d_cache_datapath (
    input  logic                    clk,
    input  logic                    reset,

    input  d_cache_pkg::cpu_req_t   req,
    input  d_cache_pkg::ctrl_t      ctrl,

    input  d_cache_pkg::line_t      pmem_rdata,
    output d_cache_pkg::line_t      cpu_rdata,
    output d_cache_pkg::line_t      pmem_wdata,
    output d_cache_pkg::addr_t      pmem_address,

    output d_cache_pkg::status_t    status
);

    // ============================================================
    // Address slicing
    // ============================================================

    d_cache_pkg::tag_t      req_tag;
    d_cache_pkg::index_t    req_index;

    assign req_tag   = req.address[`D_CACHE_ADDR_BITS-1 -: `D_CACHE_TAG_BITS];
    assign req_index = req.address[`D_CACHE_OFFSET_BITS +: `D_CACHE_INDEX_BITS];

    // ============================================================
    // Ways
    // ============================================================

    logic                   valid_0, valid_1;
    logic                   dirty_0, dirty_1;
    d_cache_pkg::tag_t      tag_0, tag_1;
    d_cache_pkg::line_t     line_0, line_1;
    logic                   hit_0, hit_1;
    logic                   victim;
    logic                   fill_0, fill_1;
    logic                   store_0, store_1;

    assign fill_0  = ctrl.load_fill && !victim;
    assign fill_1  = ctrl.load_fill && victim;
    assign store_0 = ctrl.store_cpu && hit_0;
    assign store_1 = ctrl.store_cpu && hit_1;

    d_cache_way way_0 (
        .clk        (clk),
        .reset      (reset),
        .index      (req_index),
        .tag_in     (req_tag),
        .fill       (fill_0),
        .fill_line  (pmem_rdata),
        .store      (store_0),
        .store_mask (req.byte_enable),
        .store_line (req.wdata),
        .valid      (valid_0),
        .dirty      (dirty_0),
        .tag        (tag_0),
        .line       (line_0)
    );

    d_cache_way way_1 (
        .clk        (clk),
        .reset      (reset),
        .index      (req_index),
        .tag_in     (req_tag),
        .fill       (fill_1),
        .fill_line  (pmem_rdata),
        .store      (store_1),
        .store_mask (req.byte_enable),
        .store_line (req.wdata),
        .valid      (valid_1),
        .dirty      (dirty_1),
        .tag        (tag_1),
        .line       (line_1)
    );

    // ============================================================
    // Tag compare, LRU and victim
    // ============================================================

    logic [`D_CACHE_SETS-1:0]   lru_q;     // Names the way to evict next.
    d_cache_pkg::tag_t          victim_tag;
    logic                       victim_valid;
    logic                       victim_dirty;

    assign hit_0 = valid_0 && (tag_0 == req_tag);
    assign hit_1 = valid_1 && (tag_1 == req_tag);

    assign victim       = lru_q[req_index];
    assign victim_tag   = victim ? tag_1 : tag_0;
    assign victim_valid = victim ? valid_1 : valid_0;
    assign victim_dirty = victim ? dirty_1 : dirty_0;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (ctrl.touch_lru) begin
            lru_q[req_index] <= !hit_1;     // Point at the way that was not used.
        end
    end

    assign status.hit          = hit_0 || hit_1;
    assign status.victim_dirty = victim_valid && victim_dirty;

    // ============================================================
    // Data and address out
    // ============================================================

    assign cpu_rdata  = hit_1 ? line_1 : line_0;
    assign pmem_wdata = victim ? line_1 : line_0;

    // Both sources are line aligned.
    assign pmem_address = ctrl.wb_address
        ? {victim_tag, req_index, {`D_CACHE_OFFSET_BITS{1'b0}}}
        : {req_tag, req_index, {`D_CACHE_OFFSET_BITS{1'b0}}};

    // ============================================================
    // Checks
    // ============================================================

    one_way_hits : assert property (@(posedge clk) disable iff (reset)
        !(hit_0 && hit_1));

    // The held request must find its line right after the fill lands.
    fill_then_hit : assert property (@(posedge clk) disable iff (reset)
        ctrl.load_fill |=> status.hit);

endmodule : d_cache_datapath

// File: logic/d_cache_control.sv
`timescale 1ns/1ps

module d_cache_control (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    cpu_read,
    input  logic                    cpu_write,
    input  logic                    pmem_resp,
    input  d_cache_pkg::status_t    status,

    output d_cache_pkg::ctrl_t      ctrl,
    output logic                    cache_resp,
    output logic                    pmem_read,
    output logic                    pmem_write,

    output logic                    hit,
    output logic                    miss
);

    d_cache_pkg::cache_state_t state;
    d_cache_pkg::cache_state_t state_next;
    logic                      request;

    assign request = cpu_read || cpu_write;

    // ============================================================
    // State register
    // ============================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= d_cache_pkg::compare;
        end else begin
            state <= state_next;
        end
    end

    // ============================================================
    // Next state and outputs
    // ============================================================

    always_comb begin
        state_next = state;
        ctrl       = '0;
        cache_resp = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        hit        = 1'b0;
        miss       = 1'b0;

        unique case (state)
            d_cache_pkg::compare: begin
                if (request) begin
                    if (status.hit) begin
                        cache_resp     = 1'b1;      // Hits finish in the same cycle.
                        hit            = 1'b1;
                        ctrl.touch_lru = 1'b1;
                        ctrl.store_cpu = cpu_write;
                    end else begin
                        miss = 1'b1;
                        if (status.victim_dirty) begin
                            state_next = d_cache_pkg::writeback;
                        end else begin
                            state_next = d_cache_pkg::fill;
                        end
                    end
                end
            end

            d_cache_pkg::writeback: begin
                pmem_write      = 1'b1;
                ctrl.wb_address = 1'b1;
                if (pmem_resp) begin
                    state_next = d_cache_pkg::fill;
                end
            end

            d_cache_pkg::fill: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    ctrl.load_fill = 1'b1;
                    state_next     = d_cache_pkg::compare;   // The retry then hits.
                end
            end

            default: begin
                state_next = d_cache_pkg::compare;
            end
        endcase
    end

    // ============================================================
    // Checks
    // ============================================================

    pmem_excl : assert property (@(posedge clk) disable iff (reset)
        !(pmem_read && pmem_write));

    resp_in_compare : assert property (@(posedge clk) disable iff (reset)
        $rose(cache_resp) |-> (state == d_cache_pkg::compare));

endmodule : d_cache_control

// File: logic/d_cache.sv
`timescale 1ns/1ps

module d_cache (
    input  logic                    clk,
    input  logic                    reset,

    // CPU side.
    input  logic                    mem_read,
    input  logic                    mem_write,
    input  d_cache_pkg::cpu_req_t   mem_req,
    output d_cache_pkg::line_t      mem_rdata,
    output logic                    mem_resp,

    // Memory side.
    output d_cache_pkg::addr_t      pmem_address,
    output logic                    pmem_read,
    output logic                    pmem_write,
    input  d_cache_pkg::line_t      pmem_rdata,
    output d_cache_pkg::line_t      pmem_wdata,
    input  logic                    pmem_resp,

    output logic                    hit,
    output logic                    miss
);

    d_cache_pkg::ctrl_t     ctrl;
    d_cache_pkg::status_t   status;

    d_cache_control control (
        .clk        (clk),
        .reset      (reset),
        .cpu_read   (mem_read),
        .cpu_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .status     (status),
        .ctrl       (ctrl),
        .cache_resp (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .hit        (hit),
        .miss       (miss)
    );

    d_cache_datapath datapath (
        .clk          (clk),
        .reset        (reset),
        .req          (mem_req),
        .ctrl         (ctrl),
        .pmem_rdata   (pmem_rdata),
        .cpu_rdata    (mem_rdata),
        .pmem_wdata   (pmem_wdata),
        .pmem_address (pmem_address),
        .status       (status)
    );

endmodule : d_cache

// File: bench/pmem_model.sv
`timescale 1ns/1ps
`include "d_cache_params.svh"

module pmem_model #(
    parameter int lines = 256
) (
    input  logic                clk,
    input  logic                reset,
    input  d_cache_pkg::addr_t  address,
    input  logic                read,
    input  logic                write,
    input  d_cache_pkg::line_t  wdata,
    output d_cache_pkg::line_t  rdata,
    output logic                resp,
    input  logic [3:0]          resp_delay
);

    d_cache_pkg::line_t         mem [lines];
    logic [3:0]                 waited;
    logic [$clog2(lines)-1:0]   slot;

    assign slot = address[`D_CACHE_OFFSET_BITS +: $clog2(lines)];   // Upper bits alias.

    // Every 32-bit word starts out as a scramble of its own full byte address.
    initial begin
        d_cache_pkg::addr_t word_addr;
        resp   = 1'b0;
        rdata  = '0;
        waited = '0;
        for (int i = 0; i < lines; i++) begin
            for (int w = 0; w < `D_CACHE_LINE_BITS/32; w++) begin
                word_addr = (i << `D_CACHE_OFFSET_BITS) + 4 * w;
                mem[i][32*w +: 32] = word_addr ^ {word_addr[15:0], word_addr[31:16]}
                                   ^ 32'h3c3c_a5a5;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            resp   <= 1'b0;
            waited <= '0;
            rdata  <= '0;
        end else begin
            resp <= 1'b0;
            if ((read || write) && !resp) begin     // The strobe is still high in the resp cycle.
                if (waited >= resp_delay) begin
                    resp   <= 1'b1;
                    waited <= '0;
                    if (write) begin
                        mem[slot] <= wdata;
                    end else begin
                        rdata <= mem[slot];
                    end
                end else begin
                    waited <= waited + 1'b1;
                end
            end
        end
    end

endmodule : pmem_model

// File: bench/d_cache_tb.sv
`timescale 1ns/1ps
`include "d_cache_params.svh"

module d_cache_tb;

    localparam int          mem_lines    = 256;
    localparam int          table_len    = 20;
    localparam int          resp_timeout = 200;
    localparam logic [31:0] seed         = 32'h4f10;

    typedef enum logic {
        op_read,
        op_write
    } op_t;

    typedef struct packed {
        op_t                        op;
        d_cache_pkg::addr_t         address;
        d_cache_pkg::byte_mask_t    byte_enable;
        logic                       expect_hit;
    } row_t;

    logic                   clk;
    logic                   reset;
    logic                   mem_read;
    logic                   mem_write;
    d_cache_pkg::cpu_req_t  mem_req;
    d_cache_pkg::line_t     mem_rdata;
    logic                   mem_resp;
    d_cache_pkg::addr_t     pmem_address;
    logic                   pmem_read;
    logic                   pmem_write;
    d_cache_pkg::line_t     pmem_rdata;
    d_cache_pkg::line_t     pmem_wdata;
    logic                   pmem_resp;
    logic                   hit;
    logic                   miss;
    logic [3:0]             resp_delay;

    row_t                       stim_table   [table_len];
    d_cache_pkg::line_t         shadow_mem   [mem_lines];
    d_cache_pkg::tag_t          shadow_tag   [2][`D_CACHE_SETS];
    logic [`D_CACHE_SETS-1:0]   shadow_valid [2];
    logic [`D_CACHE_SETS-1:0]   shadow_dirty [2];
    logic [`D_CACHE_SETS-1:0]   shadow_lru;

    d_cache d_cache_i (
        .clk (clk), .reset (reset),
        .mem_read (mem_read), .mem_write (mem_write), .mem_req (mem_req),
        .mem_rdata (mem_rdata), .mem_resp (mem_resp),
        .pmem_address (pmem_address), .pmem_read (pmem_read), .pmem_write (pmem_write),
        .pmem_rdata (pmem_rdata), .pmem_wdata (pmem_wdata), .pmem_resp (pmem_resp),
        .hit (hit), .miss (miss)
    );

    pmem_model #(.lines (mem_lines)) pmem_i (
        .clk (clk), .reset (reset), .address (pmem_address),
        .read (pmem_read), .write (pmem_write), .wdata (pmem_wdata),
        .rdata (pmem_rdata), .resp (pmem_resp), .resp_delay (resp_delay)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ============================================================
    // Compare tasks
    // ============================================================

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_line(input string name, input d_cache_pkg::line_t got,
                              input d_cache_pkg::line_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s expected %h got %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s expected %h got %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input d_cache_pkg::addr_t got,
                              input d_cache_pkg::addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s expected %h got %h", name, exp, got);
            abort_run();
        end
    endtask

    // ============================================================
    // Shadow models
    // ============================================================

    function automatic int mem_slot(input d_cache_pkg::addr_t a);
        return int'(a[`D_CACHE_OFFSET_BITS +: $clog2(mem_lines)]);
    endfunction

    function automatic d_cache_pkg::line_t merge_bytes(input d_cache_pkg::line_t old,
                                                       input d_cache_pkg::line_t data,
                                                       input d_cache_pkg::byte_mask_t be);
        d_cache_pkg::line_t merged;
        merged = old;
        for (int b = 0; b < `D_CACHE_LINE_BITS/8; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // Predicts hit and writeback for one request, then updates the tag state.
    task automatic predict(input row_t row, output logic pred_hit, output logic pred_wb,
                           output d_cache_pkg::addr_t wb_addr);
        d_cache_pkg::index_t idx;
        d_cache_pkg::tag_t   tg;
        logic                way;
        idx      = row.address[`D_CACHE_OFFSET_BITS +: `D_CACHE_INDEX_BITS];
        tg       = row.address[`D_CACHE_ADDR_BITS-1 -: `D_CACHE_TAG_BITS];
        pred_hit = 1'b0;
        pred_wb  = 1'b0;
        wb_addr  = '0;
        way      = shadow_lru[idx];     // Victim unless one way hits.
        if (shadow_valid[0][idx] && shadow_tag[0][idx] == tg) begin
            pred_hit = 1'b1;
            way      = 1'b0;
        end else if (shadow_valid[1][idx] && shadow_tag[1][idx] == tg) begin
            pred_hit = 1'b1;
            way      = 1'b1;
        end
        if (!pred_hit) begin
            if (shadow_valid[way][idx] && shadow_dirty[way][idx]) begin
                pred_wb = 1'b1;
                wb_addr = {shadow_tag[way][idx], idx, {`D_CACHE_OFFSET_BITS{1'b0}}};
            end
            shadow_valid[way][idx] = 1'b1;
            shadow_dirty[way][idx] = 1'b0;
            shadow_tag[way][idx]   = tg;
        end
        if (row.op == op_write) begin
            shadow_dirty[way][idx] = 1'b1;
        end
        shadow_lru[idx] = !way;
    endtask

    // ============================================================
    // Stimulus table
    // ============================================================

    task automatic put_row(input int i, input op_t op, input d_cache_pkg::addr_t address,
                           input d_cache_pkg::byte_mask_t be, input logic expect_hit);
        stim_table[i] = {op, address, be, expect_hit};
    endtask

    // Tag starts at bit 9 and set at bit 5. Rows 4 to 15 crowd set 3, all but row 10.
    task automatic load_table();
        put_row(0,  op_read,  32'h0000_0240, 32'h0000_0000, 1'b0);
        put_row(1,  op_read,  32'h0000_0240, 32'h0000_0000, 1'b1);
        put_row(2,  op_write, 32'h0000_0244, 32'h0000_00f0, 1'b1);
        put_row(3,  op_read,  32'h0000_0240, 32'h0000_0000, 1'b1);
        put_row(4,  op_read,  32'h0000_0460, 32'h0000_0000, 1'b0);
        put_row(5,  op_write, 32'h0000_0460, 32'h0000_000f, 1'b1);
        put_row(6,  op_read,  32'h0000_0860, 32'h0000_0000, 1'b0);
        put_row(7,  op_read,  32'h0000_0c60, 32'h0000_0000, 1'b0);
        put_row(8,  op_read,  32'h0000_0460, 32'h0000_0000, 1'b0);
        put_row(9,  op_write, 32'h0000_1060, 32'hffff_0000, 1'b0);
        put_row(10, op_write, 32'h0000_0020, 32'h8000_0001, 1'b0);
        put_row(11, op_read,  32'h0000_0860, 32'h0000_0000, 1'b0);
        put_row(12, op_read,  32'h0000_1060, 32'h0000_0000, 1'b1);
        put_row(13, op_write, 32'h0000_0c60, 32'hffff_ffff, 1'b0);
        put_row(14, op_read,  32'h0000_0460, 32'h0000_0000, 1'b0);
        put_row(15, op_read,  32'h0000_1060, 32'h0000_0000, 1'b0);
        put_row(16, op_read,  32'h0000_0020, 32'h0000_0000, 1'b1);
        put_row(17, op_read,  32'h0000_1fe0, 32'h0000_0000, 1'b0);
        put_row(18, op_write, 32'h0000_1fe0, 32'h0f0f_0f0f, 1'b1);
        put_row(19, op_read,  32'h0000_1fe0, 32'h0000_0000, 1'b1);
    endtask

    task automatic run_row(input int i);
        row_t                   row;
        d_cache_pkg::line_t     wdata;
        d_cache_pkg::line_t     exp_line;
        d_cache_pkg::line_t     got_line;
        d_cache_pkg::line_t     wb_data;
        d_cache_pkg::addr_t     exp_wb_addr;
        d_cache_pkg::addr_t     wb_addr;
        logic                   pred_hit;
        logic                   pred_wb;
        logic                   got_hit;
        logic                   saw_miss;
        logic                   saw_read;
        logic                   saw_wb;
        logic                   done;
        int                     cycles;
        row = stim_table[i];
        for (int w = 0; w < `D_CACHE_LINE_BITS/32; w++) begin
            wdata[32*w +: 32] = $urandom;
        end
        predict(row, pred_hit, pred_wb, exp_wb_addr);
        exp_line = shadow_mem[mem_slot(row.address)];
        mem_req    = {row.address, row.byte_enable, wdata};
        mem_read   = (row.op == op_read);
        mem_write  = (row.op == op_write);
        resp_delay = 4'($urandom % 6);
        saw_miss = 1'b0;
        saw_read = 1'b0;
        saw_wb   = 1'b0;
        done     = 1'b0;
        cycles   = 0;
        while (!done) begin
            @(negedge clk);
            saw_miss = saw_miss || miss;
            saw_read = saw_read || pmem_read;
            if (pmem_write && pmem_resp) begin
                saw_wb  = 1'b1;
                wb_addr = pmem_address;
                wb_data = pmem_wdata;
            end
            if (mem_resp) begin
                done     = 1'b1;
                got_line = mem_rdata;
                got_hit  = hit;
            end else begin
                cycles++;
                if (cycles >= resp_timeout) begin
                    $display("Row %0d got no mem_resp within %0d cycles", i, resp_timeout);
                    abort_run();
                end
            end
        end
        check_flag("expect_hit", pred_hit, row.expect_hit);
        check_flag("miss", saw_miss, !pred_hit);
        check_flag("hit", got_hit, 1'b1);       // A miss ends with the retry hitting.
        check_flag("pmem_read", saw_read, !pred_hit);
        check_flag("pmem_write", saw_wb, pred_wb);
        if (pred_wb) begin
            check_addr("pmem_address", wb_addr, exp_wb_addr);
            check_line("pmem_wdata", wb_data, shadow_mem[mem_slot(exp_wb_addr)]);
        end
        if (row.op == op_write) begin
            shadow_mem[mem_slot(row.address)] = merge_bytes(exp_line, wdata, row.byte_enable);
        end else begin
            check_line("mem_rdata", got_line, exp_line);
        end
        @(posedge clk);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        void'($urandom(seed));
        reset      = 1'b1;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_req    = '0;
        resp_delay = '0;
        shadow_valid[0] = '0;
        shadow_valid[1] = '0;
        shadow_dirty[0] = '0;
        shadow_dirty[1] = '0;
        shadow_lru      = '0;
        load_table();
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < mem_lines; i++) begin
            shadow_mem[i] = pmem_i.mem[i];      // Start from the memory's preset contents.
        end
        @(negedge clk);
        check_flag("mem_resp", mem_resp, 1'b0);
        check_flag("pmem_read", pmem_read, 1'b0);
        check_flag("pmem_write", pmem_write, 1'b0);
        check_flag("hit", hit, 1'b0);
        check_flag("miss", miss, 1'b0);
        @(posedge clk);
        #1;
        for (int i = 0; i < table_len; i++) begin
            run_row(i);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule : d_cache_tb

// File: sim.f
+incdir+logic
logic/d_cache_pkg.sv
logic/d_cache_way.sv
logic/d_cache_datapath.sv
logic/d_cache_control.sv
logic/d_cache.sv
bench/pmem_model.sv
bench/d_cache_tb.sv
